/* vdp_pkg.sv */
package vdp_pkg;

    // horizontal timing in pixel clocks
    localparam int H_VISIBLE = 16;
    localparam int H_FRONT   = 2;
    localparam int H_SYNC    = 4;
    localparam int H_BACK    = 2;
    localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;   // 24

    // vertical timing in lines
    localparam int V_VISIBLE = 8;
    localparam int V_FRONT   = 1;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 1;
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;   // 12

    localparam int HCNT_W    = 5;           // fits H_TOTAL-1
    localparam int VCNT_W    = 4;           // fits V_TOTAL-1

    localparam int VRAM_AW       = 8;       // 256 words
    localparam int PIX_PER_WORD  = 4;       // 4-bit pixels, msn first
    localparam int WORDS_PER_ROW = H_VISIBLE / PIX_PER_WORD;
    // fetch runs this many clocks ahead of the pixel
    // two for the vram pipe, one for the shifter load
    localparam int FETCH_LEAD    = 3;

    // host register numbers
    typedef enum logic [3:0] {
        REG_AUX_ADDR = 4'd0,
        REG_AUX_DATA = 4'd1,    // commit writes aux space
        REG_WR_INC   = 4'd2,
        REG_WR_ADDR  = 4'd3,
        REG_WR_DATA  = 4'd4,    // commit writes vram
        REG_RD_ADDR  = 4'd5,    // commit starts a vram read
        REG_RD_DATA  = 4'd6,
        REG_SYS_CTRL = 4'd7     // [15] busy, [0] video enable
    } reg_num_e;

    // aux window from address bits 15:14
    typedef enum logic [1:0] {
        AUX_VID      = 2'd0,    // video regs
        AUX_COLOR    = 2'd1,    // palette
        AUX_NONE     = 2'd2,
        AUX_NONE_ALT = 2'd3     // also unmapped
    } aux_win_e;

    // one host bus cycle
    typedef struct packed {
        logic     cs_n;         // active low strobe
        logic     rd_nwr;       // 1 = read
        reg_num_e reg_num;
        logic     bytesel;      // 0 = high byte, 1 = low byte
        logic [7:0] data;
    } host_bus_t;

    // single pending request from the register block
    typedef struct packed {
        logic        vram_sel;
        logic        aux_sel;
        logic        wr;
        logic [15:0] addr;
        logic [15:0] wdata;
    } mem_req_t;

    // video generator output, one pixel per clock
    typedef struct packed {
        logic [3:0] pal_index;
        logic       hsync;
        logic       vsync;
        logic       blank;      // vertical blank
        logic       de;
    } video_out_t;

endpackage

/* vdp_palette_ram.sv */
`timescale 1ns/1ps

module vdp_palette_ram (
    input  logic        clk,
    input  logic        wr_i,
    input  logic [3:0]  waddr_i,
    input  logic [11:0] wdata_i,
    input  logic [3:0]  raddr_i,
    output logic [11:0] rdata_o
);

    logic [11:0] mem [16];              // {r, g, b} per entry

    // host side write
    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // video side, one clock read
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

/* vdp_vram.sv */
`timescale 1ns/1ps

module vdp_vram import vdp_pkg::*; (
    input  logic               clk,
    input  logic               sel_i,
    input  logic               wr_i,
    input  logic [VRAM_AW-1:0] addr_i,
    input  logic [15:0]        wdata_i,
    output logic [15:0]        rdata_o
);

    logic [15:0] mem [2**VRAM_AW];
    logic [15:0] rd_q;                  // bram read register

    always_ff @(posedge clk) begin
        if (sel_i) begin
            if (wr_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rd_q <= mem[addr_i];
            end
        end
    end

    // output stage, data valid two clocks after sel
    always_ff @(posedge clk) begin
        rdata_o <= rd_q;
    end

endmodule

/* vdp_bus_regs.sv */
`timescale 1ns/1ps

module vdp_bus_regs import vdp_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  host_bus_t   bus_i,
    output logic [7:0]  bus_data_o,
    output mem_req_t    req_o,
    input  logic        req_grant_i,
    input  logic [15:0] rdata_i,
    output logic        vid_ena_o
);

    logic [7:0]  hi_byte_q;             // byte assembly latch
    logic [15:0] aux_addr_q;
    logic [15:0] aux_data_q;
    logic [15:0] wr_inc_q;
    logic [15:0] wr_addr_q;
    logic [15:0] wr_data_q;
    logic [15:0] rd_addr_q;
    logic [15:0] rd_data_q;
    logic        busy_q;
    logic [1:0]  rd_pipe_q;             // tracks vram read latency
    mem_req_t    req_q;

    logic        wr_stb;
    logic        rd_stb;
    logic        commit;
    logic        rd_next;               // low byte of RD_DATA read
    logic        req_done;
    logic [15:0] word;
    logic [15:0] reg_word;

    function automatic mem_req_t make_req(
        input logic        vram,
        input logic        wr,
        input logic [15:0] addr,
        input logic [15:0] wdata
    );
        mem_req_t r;
        r.vram_sel = vram;
        r.aux_sel  = ~vram;
        r.wr       = wr;
        r.addr     = addr;
        r.wdata    = wdata;
        return r;
    endfunction

    assign wr_stb   = ~bus_i.cs_n & ~bus_i.rd_nwr;
    assign rd_stb   = ~bus_i.cs_n & bus_i.rd_nwr;
    assign commit   = wr_stb & bus_i.bytesel;   // low byte completes the word
    assign word     = {hi_byte_q, bus_i.data};
    assign rd_next  = rd_stb && bus_i.bytesel && (bus_i.reg_num == REG_RD_DATA) && !busy_q;
    assign req_done = (req_q.vram_sel | req_q.aux_sel) & req_grant_i;

    assign req_o     = req_q;

    // host read mux
    always_comb begin
        case (bus_i.reg_num)
            REG_AUX_ADDR: reg_word = aux_addr_q;
            REG_AUX_DATA: reg_word = aux_data_q;
            REG_WR_INC:   reg_word = wr_inc_q;
            REG_WR_ADDR:  reg_word = wr_addr_q;
            REG_WR_DATA:  reg_word = wr_data_q;
            REG_RD_ADDR:  reg_word = rd_addr_q;
            REG_RD_DATA:  reg_word = rd_data_q;
            REG_SYS_CTRL: reg_word = {busy_q, 14'd0, vid_ena_o};
            default:      reg_word = 16'h0000;
        endcase
    end

    // control state, requests and address updates
    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q         <= 1'b0;
            rd_pipe_q      <= 2'b00;
            req_q.vram_sel <= 1'b0;
            req_q.aux_sel  <= 1'b0;
            vid_ena_o      <= 1'b0;
            bus_data_o     <= 8'h00;
            aux_addr_q     <= 16'h0000;
            wr_inc_q       <= 16'h0000;
            wr_addr_q      <= 16'h0000;
            rd_addr_q      <= 16'h0000;
        end else begin
            rd_pipe_q <= {rd_pipe_q[0], req_done & req_q.vram_sel & ~req_q.wr};

            if (req_done) begin
                req_q.vram_sel <= 1'b0;
                req_q.aux_sel  <= 1'b0;
                if (req_q.wr) begin
                    busy_q <= 1'b0;                         // writes done at grant
                    if (req_q.vram_sel) begin
                        wr_addr_q <= wr_addr_q + wr_inc_q;  // auto increment
                    end
                end
            end
            if (rd_pipe_q[1]) begin
                busy_q <= 1'b0;                 // read word landed in RD_DATA
            end

            if (rd_stb) begin
                bus_data_o <= bus_i.bytesel ? reg_word[7:0] : reg_word[15:8];
            end
            if (rd_next) begin
                rd_addr_q <= rd_addr_q + 16'd1;
                req_q     <= make_req(1'b1, 1'b0, rd_addr_q + 16'd1, 16'h0000);
                busy_q    <= 1'b1;
            end

            if (commit) begin
                case (bus_i.reg_num)
                    REG_AUX_ADDR: aux_addr_q <= word;
                    REG_AUX_DATA: begin
                        if (!busy_q) begin
                            req_q  <= make_req(1'b0, 1'b1, aux_addr_q, word);
                            busy_q <= 1'b1;
                        end
                    end
                    REG_WR_INC:   wr_inc_q  <= word;
                    REG_WR_ADDR:  wr_addr_q <= word;
                    REG_WR_DATA: begin
                        if (!busy_q) begin
                            req_q  <= make_req(1'b1, 1'b1, wr_addr_q, word);
                            busy_q <= 1'b1;
                        end
                    end
                    REG_RD_ADDR: begin
                        if (!busy_q) begin
                            rd_addr_q <= word;
                            req_q     <= make_req(1'b1, 1'b0, word, 16'h0000);
                            busy_q    <= 1'b1;
                        end
                    end
                    REG_SYS_CTRL: vid_ena_o <= word[0];
                    default: ;                  // RD_DATA is read only
                endcase
            end
        end
    end

    // data registers
    always_ff @(posedge clk) begin
        if (wr_stb && !bus_i.bytesel) begin
            hi_byte_q <= bus_i.data;
        end
        if (commit && !busy_q) begin
            if (bus_i.reg_num == REG_WR_DATA) begin
                wr_data_q <= word;
            end
            if (bus_i.reg_num == REG_AUX_DATA) begin
                aux_data_q <= word;
            end
        end
        if (rd_pipe_q[1]) begin
            rd_data_q <= rdata_i;               // two clocks after grant
        end
    end

endmodule

/* vdp_video_gen.sv */
`timescale 1ns/1ps

module vdp_video_gen import vdp_pkg::*; (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               ena_i,
    input  logic               vreg_wr_i,
    input  logic [3:0]         vreg_num_i,
    input  logic [15:0]        vreg_data_i,
    output logic               vram_rd_o,
    output logic [VRAM_AW-1:0] vram_addr_o,
    input  logic [15:0]        vram_data_i,
    output video_out_t         vout_o
);

    logic [HCNT_W-1:0] h_cnt;
    logic [VCNT_W-1:0] v_cnt;
    logic [15:0]       base_q;          // display base word address
    logic [3:0]        border_q;        // border palette index
    logic [15:0]       shift_q;         // pixel shifter
    logic [1:0]        rd_pipe_q;       // matches vram read latency

    logic [HCNT_W-1:0] fetch_h;         // pixel position being fetched
    logic [VCNT_W-1:0] fetch_v;
    logic              h_vis;
    logic              v_vis;
    logic              visible;

    // counters
    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == HCNT_W'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            if (v_cnt == VCNT_W'(V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // video regs through the aux window
    always_ff @(posedge clk) begin
        if (reset_i) begin
            base_q   <= 16'h0000;
            border_q <= 4'h0;
        end else if (vreg_wr_i) begin
            case (vreg_num_i)
                4'd0:    base_q   <= vreg_data_i;
                4'd1:    border_q <= vreg_data_i[3:0];
                default: ;                      // unused regs
            endcase
        end
    end

    // position FETCH_LEAD clocks ahead, wraps into next line
    always_comb begin
        if (h_cnt >= HCNT_W'(H_TOTAL - FETCH_LEAD)) begin
            fetch_h = h_cnt - HCNT_W'(H_TOTAL - FETCH_LEAD);
            if (v_cnt == VCNT_W'(V_TOTAL - 1)) begin
                fetch_v = '0;
            end else begin
                fetch_v = v_cnt + 1'b1;
            end
        end else begin
            fetch_h = h_cnt + HCNT_W'(FETCH_LEAD);
            fetch_v = v_cnt;
        end
    end

    // one fetch at the start of every pixel group
    assign vram_rd_o = ena_i
                     && (fetch_h < HCNT_W'(H_VISIBLE))
                     && (fetch_v < VCNT_W'(V_VISIBLE))
                     && (fetch_h % HCNT_W'(PIX_PER_WORD) == '0);
    assign vram_addr_o = base_q[VRAM_AW-1:0]
                       + VRAM_AW'(fetch_v) * VRAM_AW'(WORDS_PER_ROW)
                       + VRAM_AW'(fetch_h / HCNT_W'(PIX_PER_WORD));

    // shifter, loaded on the last clock of the previous group
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_pipe_q <= 2'b00;
        end else begin
            rd_pipe_q <= {rd_pipe_q[0], vram_rd_o};
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pipe_q[1]) begin
            shift_q <= vram_data_i;
        end else begin
            shift_q <= {shift_q[11:0], 4'h0};   // next nibble up
        end
    end

    assign h_vis   = h_cnt < HCNT_W'(H_VISIBLE);
    assign v_vis   = v_cnt < VCNT_W'(V_VISIBLE);
    assign visible = h_vis & v_vis;

    // registered timing outputs
    always_ff @(posedge clk) begin
        if (reset_i) begin
            vout_o <= '0;
        end else begin
            vout_o.pal_index <= (visible && ena_i) ? shift_q[15:12] : border_q;
            vout_o.hsync     <= (h_cnt >= HCNT_W'(H_VISIBLE + H_FRONT))
                             && (h_cnt < HCNT_W'(H_VISIBLE + H_FRONT + H_SYNC));
            vout_o.vsync     <= (v_cnt >= VCNT_W'(V_VISIBLE + V_FRONT))
                             && (v_cnt < VCNT_W'(V_VISIBLE + V_FRONT + V_SYNC));
            vout_o.blank     <= ~v_vis;
            vout_o.de        <= visible & ena_i;
        end
    end

endmodule

/* vdp_main.sv */
`timescale 1ns/1ps

module vdp_main import vdp_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  host_bus_t  bus_i,
    output logic [7:0] bus_data_o,
    output logic [3:0] red_o,
    output logic [3:0] green_o,
    output logic [3:0] blue_o,
    output logic       hsync_o,
    output logic       vsync_o,
    output logic       dv_de_o,
    output logic       vblank_o
);

    mem_req_t           req;
    logic               req_grant;
    logic               vid_ena;

    logic               vgen_rd;            // video fetch this clock
    logic [VRAM_AW-1:0] vgen_addr;
    logic               vram_sel;
    logic               vram_wr;
    logic [VRAM_AW-1:0] vram_addr;
    logic [15:0]        vram_rdata;

    aux_win_e           aux_win;
    logic               aux_wr;
    logic               pal_wr;
    logic               vreg_wr;

    video_out_t         vout;
    video_out_t         vout_d;             // lines up with palette read
    logic [11:0]        pal_rgb;

    // video always wins the vram port
    assign vram_sel  = vgen_rd | req.vram_sel;
    assign vram_wr   = ~vgen_rd & req.vram_sel & req.wr;
    assign vram_addr = vgen_rd ? vgen_addr : req.addr[VRAM_AW-1:0];
    assign req_grant = (req.vram_sel & ~vgen_rd) | req.aux_sel;    // aux never waits

    // aux window decode
    assign aux_win = aux_win_e'(req.addr[15:14]);
    assign aux_wr  = req.aux_sel & req.wr;
    assign pal_wr  = aux_wr && (aux_win == AUX_COLOR);
    assign vreg_wr = aux_wr && (aux_win == AUX_VID);   // AUX_NONE writes fall away

    vdp_bus_regs vdp_bus_regs_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .bus_i       (bus_i),
        .bus_data_o  (bus_data_o),
        .req_o       (req),
        .req_grant_i (req_grant),
        .rdata_i     (vram_rdata),
        .vid_ena_o   (vid_ena)
    );

    vdp_video_gen vdp_video_gen_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .ena_i       (vid_ena),
        .vreg_wr_i   (vreg_wr),
        .vreg_num_i  (req.addr[3:0]),
        .vreg_data_i (req.wdata),
        .vram_rd_o   (vgen_rd),
        .vram_addr_o (vgen_addr),
        .vram_data_i (vram_rdata),
        .vout_o      (vout)
    );

    vdp_vram vdp_vram_inst (
        .clk     (clk),
        .sel_i   (vram_sel),
        .wr_i    (vram_wr),
        .addr_i  (vram_addr),
        .wdata_i (req.wdata),
        .rdata_o (vram_rdata)
    );

    vdp_palette_ram vdp_palette_ram_inst (
        .clk     (clk),
        .wr_i    (pal_wr),
        .waddr_i (req.addr[3:0]),
        .wdata_i (req.wdata[11:0]),
        .raddr_i (vout.pal_index),
        .rdata_o (pal_rgb)
    );

    // syncs wait one clock for the palette, then everything is registered together
    always_ff @(posedge clk) begin
        if (reset_i) begin
            vout_d   <= '0;
            hsync_o  <= 1'b0;
            vsync_o  <= 1'b0;
            dv_de_o  <= 1'b0;
            vblank_o <= 1'b0;
            red_o    <= 4'h0;
            green_o  <= 4'h0;
            blue_o   <= 4'h0;
        end else begin
            vout_d   <= vout;
            hsync_o  <= vout_d.hsync;
            vsync_o  <= vout_d.vsync;
            dv_de_o  <= vout_d.de;
            vblank_o <= vout_d.blank;
            red_o    <= vout_d.de ? pal_rgb[11:8] : 4'h0;  // black outside display
            green_o  <= vout_d.de ? pal_rgb[7:4]  : 4'h0;
            blue_o   <= vout_d.de ? pal_rgb[3:0]  : 4'h0;
        end
    end

endmodule

/* tb_vdp_main.sv */
`timescale 1ns/1ps

module tb_vdp_main import vdp_pkg::*; ();

    typedef enum logic [1:0] {
        OP_WRITE,                           // 16-bit register write
        OP_READ,                            // 16-bit read and compare
        OP_FRAME                            // watch one whole frame
    } op_e;

    typedef struct packed {
        op_e         kind;
        reg_num_e    rnum;
        logic [15:0] data;                  // write data or enable flag for a frame
        logic [15:0] expv;
    } step_t;

    logic        clk;
    logic        reset_i;
    host_bus_t   bus;
    logic [7:0]  bus_data_o;
    logic [3:0]  red_o;
    logic [3:0]  green_o;
    logic [3:0]  blue_o;
    logic        hsync_o;
    logic        vsync_o;
    logic        dv_de_o;
    logic        vblank_o;

    step_t       steps[$];
    string       names[$];
    integer      seed = 32'h36b;
    int unsigned cycles = 0;
    int unsigned cycle_limit = 32'hffff_ffff;

    // model state kept by the register rules
    logic [15:0] m_vram [256];
    logic [11:0] m_pal [16];
    logic [15:0] m_base = 16'h0000;
    logic [15:0] m_wr_addr = 16'h0000;
    logic [15:0] m_wr_inc = 16'h0000;
    logic [15:0] m_rd_addr = 16'h0000;
    logic [15:0] m_aux_addr = 16'h0000;

    vdp_main vdp_main_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .bus_i      (bus),
        .bus_data_o (bus_data_o),
        .red_o      (red_o),
        .green_o    (green_o),
        .blue_o     (blue_o),
        .hsync_o    (hsync_o),
        .vsync_o    (vsync_o),
        .dv_de_o    (dv_de_o),
        .vblank_o   (vblank_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [15:0] expv,
                               input logic [15:0] act);
        assert (act === expv) else begin
            $display("MISMATCH %s expected %h actual %h", name, expv, act);
            $display("sim failed");
            $fatal(1, "check failed");
        end
    endtask

    // one strobe cycle plus one idle cycle that returns the byte read back
    task automatic single_access(input logic rd, input reg_num_e rnum, input logic bsel,
                                 input logic [7:0] d, output logic [7:0] q);
        bus.cs_n    = 1'b0;
        bus.rd_nwr  = rd;
        bus.reg_num = rnum;
        bus.bytesel = bsel;
        bus.data    = d;
        @(negedge clk);
        bus.cs_n = 1'b1;
        q        = bus_data_o;              // updated on the last rising edge
        @(negedge clk);
    endtask

    task automatic wait_not_busy();
        logic [7:0] st;
        st = 8'h80;
        while (st[7]) begin
            single_access(1'b1, REG_SYS_CTRL, 1'b0, 8'h00, st);   // busy is bit 15
        end
    endtask

    task automatic bus_write(input reg_num_e rnum, input logic [15:0] d);
        logic [7:0] unused;
        single_access(1'b0, rnum, 1'b0, d[15:8], unused);
        single_access(1'b0, rnum, 1'b1, d[7:0], unused);  // low byte commits
        wait_not_busy();
    endtask

    task automatic bus_read(input reg_num_e rnum, output logic [15:0] d);
        logic [7:0] hi;
        logic [7:0] lo;
        single_access(1'b1, rnum, 1'b0, 8'h00, hi);
        single_access(1'b1, rnum, 1'b1, 8'h00, lo);
        d = {hi, lo};
        wait_not_busy();                    // low byte of RD_DATA starts the next read
    endtask

    function automatic void add_write(input string name, input reg_num_e rnum,
                                      input logic [15:0] d);
        steps.push_back({OP_WRITE, rnum, d, 16'h0000});
        names.push_back(name);
        case (rnum)
            REG_WR_INC:   m_wr_inc = d;
            REG_WR_ADDR:  m_wr_addr = d;
            REG_RD_ADDR:  m_rd_addr = d;
            REG_AUX_ADDR: m_aux_addr = d;
            REG_WR_DATA: begin
                m_vram[m_wr_addr[7:0]] = d;
                m_wr_addr = m_wr_addr + m_wr_inc;
            end
            REG_AUX_DATA: begin
                if (m_aux_addr[15:14] == 2'd1) begin
                    m_pal[m_aux_addr[3:0]] = d[11:0];
                end else if (m_aux_addr[15:14] == 2'd0 && m_aux_addr[3:0] == 4'd0) begin
                    m_base = d;
                end                         // border and windows 2, 3 change no colour
            end
            default: ;
        endcase
    endfunction

    function automatic void add_vram_read(input string name);
        steps.push_back({OP_READ, REG_RD_DATA, 16'h0000, m_vram[m_rd_addr[7:0]]});
        names.push_back(name);
        m_rd_addr = m_rd_addr + 16'd1;
    endfunction

    function automatic void add_frame(input string name, input logic en);
        steps.push_back({OP_FRAME, REG_SYS_CTRL, {15'd0, en}, 16'h0000});
        names.push_back(name);
    endfunction

    // one frame from the end of vsync to the end of the next one
    task automatic check_frame(input string name, input logic en);
        int          de_run;
        int          de_total;
        int          lines;
        int          hs_run;
        int          hs_pulses;
        int          last_rise;
        int          vs_cyc;
        logic        prev_de;
        logic        prev_hs;
        logic        exp_vb;
        logic [7:0]  widx;
        logic [15:0] w;
        logic [11:0] exp_rgb;
        de_run    = 0;
        de_total  = 0;
        lines     = 0;
        hs_run    = 0;
        hs_pulses = 0;
        last_rise = 0;
        vs_cyc    = 0;
        prev_de   = 1'b0;
        prev_hs   = 1'b0;
        while (!vsync_o) @(negedge clk);
        while (vsync_o) @(negedge clk);
        for (int cyc = 0; cyc < H_TOTAL * V_TOTAL; cyc++) begin
            exp_rgb = 12'h000;
            if (dv_de_o) begin
                widx    = m_base[7:0] + 8'(lines * WORDS_PER_ROW) + 8'(de_run / 4);
                w       = m_vram[widx];
                exp_rgb = m_pal[w[4 * (3 - de_run % 4) +: 4]];   // msn first
                de_run++;
                de_total++;
            end else if (prev_de) begin
                check_value({name, " de per line"}, 16'(H_VISIBLE), 16'(de_run));
                lines++;
                de_run = 0;
            end
            check_value({name, " colour"}, {4'h0, exp_rgb}, {4'h0, red_o, green_o, blue_o});
            // window opens on the back porch line
            exp_vb = ((cyc / H_TOTAL + V_TOTAL - V_BACK) % V_TOTAL) >= V_VISIBLE;
            check_value({name, " vblank"}, {15'd0, exp_vb}, {15'd0, vblank_o});
            if (hsync_o) begin
                if (!prev_hs) begin
                    if (hs_pulses > 0) begin
                        check_value({name, " hsync period"}, 16'(H_TOTAL),
                                    16'(cyc - last_rise));
                    end
                    last_rise = cyc;
                    hs_pulses++;
                end
                hs_run++;
            end else if (prev_hs) begin
                check_value({name, " hsync width"}, 16'(H_SYNC), 16'(hs_run));
                hs_run = 0;
            end
            if (vsync_o) vs_cyc++;
            prev_de = dv_de_o;
            prev_hs = hsync_o;
            @(negedge clk);
        end
        check_value({name, " visible lines"}, en ? 16'(V_VISIBLE) : 16'd0, 16'(lines));
        check_value({name, " de cycles"}, en ? 16'(H_VISIBLE * V_VISIBLE) : 16'd0,
                    16'(de_total));
        check_value({name, " hsync pulses"}, 16'(V_TOTAL), 16'(hs_pulses));
        check_value({name, " vsync length"}, 16'(V_SYNC * H_TOTAL), 16'(vs_cyc));
    endtask

    initial begin
        integer      r;
        logic [15:0] got;
        bus     = '0;
        bus.cs_n = 1'b1;
        reset_i = 1'b1;

        // linear fill and read back
        add_write("wr_inc", REG_WR_INC, 16'd1);
        add_write("wr_addr", REG_WR_ADDR, 16'd0);
        for (int i = 0; i < 32; i++) begin
            r = $random(seed);
            add_write($sformatf("vram_wr[%0d]", i), REG_WR_DATA, r[15:0]);
        end
        add_write("rd_addr", REG_RD_ADDR, 16'd0);
        for (int i = 0; i < 32; i++) add_vram_read($sformatf("vram_rd[%0d]", i));

        // stride 4 from word 4 up to word 32
        add_write("wr_inc4", REG_WR_INC, 16'd4);
        add_write("wr_addr4", REG_WR_ADDR, 16'd4);
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            add_write($sformatf("stride_wr[%0d]", i), REG_WR_DATA, r[15:0]);
        end
        for (int i = 0; i < 8; i++) begin
            add_write($sformatf("stride_addr[%0d]", i), REG_RD_ADDR, 16'(4 + 4 * i));
            add_vram_read($sformatf("stride_rd[%0d]", i));
        end

        // palette, base word 1, border, then two unmapped writes
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            add_write($sformatf("pal_addr[%0d]", i), REG_AUX_ADDR, 16'h4000 | 16'(i));
            add_write($sformatf("pal_data[%0d]", i), REG_AUX_DATA, {4'h0, r[11:0]});
        end
        add_write("base_addr", REG_AUX_ADDR, 16'h0000);
        add_write("base_data", REG_AUX_DATA, 16'h0001);
        add_write("border_addr", REG_AUX_ADDR, 16'h0001);
        add_write("border_data", REG_AUX_DATA, 16'h0007);
        add_write("none_addr2", REG_AUX_ADDR, 16'h8000);
        add_write("none_data2", REG_AUX_DATA, 16'h0abc);
        add_write("none_addr3", REG_AUX_ADDR, 16'hc000);
        add_write("none_data3", REG_AUX_DATA, 16'h0010);

        add_write("video_on", REG_SYS_CTRL, 16'h0001);
        add_frame("frame_on", 1'b1);
        add_write("video_off", REG_SYS_CTRL, 16'h0000);
        add_frame("frame_off", 1'b0);

        cycle_limit = steps.size() * 40 + 4 * H_TOTAL * V_TOTAL;

        repeat (4) @(negedge clk);
        reset_i = 1'b0;
        @(negedge clk);

        for (int i = 0; i < steps.size(); i++) begin
            case (steps[i].kind)
                OP_WRITE: bus_write(steps[i].rnum, steps[i].data);
                OP_READ: begin
                    bus_read(steps[i].rnum, got);
                    check_value(names[i], steps[i].expv, got);
                end
                default: check_frame(names[i], steps[i].data[0]);
            endcase
        end

        $display("sim passed");
        $finish;
    end

endmodule

/* all.f */
vdp_pkg.sv
vdp_palette_ram.sv
vdp_vram.sv
vdp_bus_regs.sv
vdp_video_gen.sv
vdp_main.sv
tb_vdp_main.sv

/* run.sh */
#!/bin/sh
# compile with Verilator and run, exit status follows the testbench
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f all.f --top-module tb_vdp_main -o tb_vdp_main \
    && ./obj_dir/tb_vdp_main \
    || exit 1
